//--- hw/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Address of the first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Fetching from this address stops the core
`define MIPS_HALT_ADDRESS 32'h00000000

// Register that jal writes the return address into
`define MIPS_LINK_REG 5'd31

`endif

//--- hw/mips_pkg.sv
package mips_pkg;

  // Data words and byte addresses share one width
  typedef logic [31:0] word_t;

  // Register number as found in the rs, rt and rd fields
  typedef logic [4:0] reg_addr_t;

  // Constant shift amount taken from instruction bits 10 to 6
  typedef logic [4:0] shamt_t;

  // Operations the ALU can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_t;

  // Width and extension of a load result
  typedef enum logic [2:0] {
    LOAD_WORD,
    LOAD_BYTE_SIGNED,
    LOAD_BYTE_UNSIGNED,
    LOAD_HALF_SIGNED,
    LOAD_HALF_UNSIGNED
  } load_kind_t;

endpackage

//--- hw/mips_ctrl_if.sv
`timescale 1ns/1ps

interface mips_ctrl_if;
  import mips_pkg::*;

  // Levels the decoder drives for the current instruction
  alu_op_t    alu_op;
  logic       alu_src;
  logic       sign_ext_imm;
  logic       reg_write;
  logic       reg_dst_rd;
  logic       reg_dst_link;
  logic       mem_to_reg;
  logic       link_to_reg;
  load_kind_t load_kind;
  logic       pc_src;
  logic       jump;
  logic       jump_reg;

  // Returned by the datapath so the decoder can resolve branches
  word_t      instr;
  logic       zero;

  modport ctrl (
    input  instr, zero,
    output alu_op, alu_src, sign_ext_imm, reg_write, reg_dst_rd, reg_dst_link,
    output mem_to_reg, link_to_reg, load_kind, pc_src, jump, jump_reg
  );

  modport dp (
    input  alu_op, alu_src, sign_ext_imm, reg_write, reg_dst_rd, reg_dst_link,
    input  mem_to_reg, link_to_reg, load_kind, pc_src, jump, jump_reg,
    output instr, zero
  );

endinterface

//--- hw/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
  input  mips_pkg::alu_op_t op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::shamt_t  shamt,
  output mips_pkg::word_t   y,
  output logic              zero
);
  import mips_pkg::*;

  // Single combinational stage, the result is ready in the same cycle
  always_comb begin
    case (op)
      // Address arithmetic and addiu use the same wrapping add
      ALU_ADD: y = a + b;
      // Also drives the zero flag for beq and bne
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      ALU_NOR: y = ~(a | b);
      // Compares leave a single bit in the lowest position
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      // Shifts move the rt operand, the rs operand is ignored
      ALU_SLL: y = b << shamt;
      ALU_SRL: y = b >> shamt;
      ALU_SRA: y = word_t'($signed(b) >>> shamt);
      // The immediate lands in the upper half with zeros below
      ALU_LUI: y = {b[15:0], 16'h0000};
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

//--- hw/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2,
  output mips_pkg::word_t     reg_v0
);
  import mips_pkg::*;

  word_t regs [32];

  // All registers clear on reset so a program starts from a known state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Reads are asynchronous; $0 reads zero whatever was written to it
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  // $v0 holds the result a finished program leaves behind
  assign reg_v0 = regs[2];

endmodule

//--- hw/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
  mips_ctrl_if.ctrl ctrl,
  output logic      data_write,
  output logic      data_read
);
  import mips_pkg::*;

  // Opcodes of the supported subset
  localparam logic [5:0] OP_RTYPE = 6'h00, OP_J    = 6'h02, OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04, OP_BNE  = 6'h05, OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0A, OP_SLTIU = 6'h0B, OP_ANDI = 6'h0C;
  localparam logic [5:0] OP_ORI   = 6'h0D, OP_XORI = 6'h0E, OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LB    = 6'h20, OP_LH   = 6'h21, OP_LW    = 6'h23;
  localparam logic [5:0] OP_LBU   = 6'h24, OP_LHU  = 6'h25, OP_SW    = 6'h2B;

  // Function codes of the R-type instructions
  localparam logic [5:0] FN_SLL = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03;
  localparam logic [5:0] FN_JR  = 6'h08, FN_JALR = 6'h09, FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR = 6'h26, FN_NOR  = 6'h27, FN_SLT  = 6'h2A;
  localparam logic [5:0] FN_SLTU = 6'h2B;

  logic [5:0] opcode;
  logic [5:0] funct;
  alu_op_t    funct_op;
  logic       funct_alu;
  logic       funct_jr;
  logic       funct_jalr;
  logic       is_beq;
  logic       is_bne;

  assign opcode = ctrl.instr[31:26];
  assign funct  = ctrl.instr[5:0];

  // ALU-function decoder for the R-type group
  always_comb begin
    funct_op   = ALU_ADD;
    funct_alu  = 1'b1;
    funct_jr   = 1'b0;
    funct_jalr = 1'b0;
    case (funct)
      FN_SLL:  funct_op = ALU_SLL;
      FN_SRL:  funct_op = ALU_SRL;
      FN_SRA:  funct_op = ALU_SRA;
      FN_ADDU: funct_op = ALU_ADD;
      FN_SUBU: funct_op = ALU_SUB;
      FN_AND:  funct_op = ALU_AND;
      FN_OR:   funct_op = ALU_OR;
      FN_XOR:  funct_op = ALU_XOR;
      FN_NOR:  funct_op = ALU_NOR;
      FN_SLT:  funct_op = ALU_SLT;
      FN_SLTU: funct_op = ALU_SLTU;
      FN_JR: begin
        funct_alu = 1'b0;
        funct_jr  = 1'b1;
      end
      FN_JALR: begin
        funct_alu  = 1'b0;
        funct_jalr = 1'b1;
      end
      // Unknown functions write nothing
      default: funct_alu = 1'b0;
    endcase
  end

  // Every level of the main decoder starts inactive so unknown opcodes act as a nop
  always_comb begin
    ctrl.alu_op       = ALU_ADD;
    ctrl.alu_src      = 1'b0;
    ctrl.sign_ext_imm = 1'b1;
    ctrl.reg_write    = 1'b0;
    ctrl.reg_dst_rd   = 1'b0;
    ctrl.reg_dst_link = 1'b0;
    ctrl.mem_to_reg   = 1'b0;
    ctrl.link_to_reg  = 1'b0;
    ctrl.load_kind    = LOAD_WORD;
    ctrl.jump         = 1'b0;
    ctrl.jump_reg     = 1'b0;
    is_beq            = 1'b0;
    is_bne            = 1'b0;
    data_write        = 1'b0;
    data_read         = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        ctrl.alu_op      = funct_op;
        ctrl.reg_dst_rd  = 1'b1;
        ctrl.reg_write   = funct_alu | funct_jalr;
        // jalr links into rd while jr writes nothing
        ctrl.link_to_reg = funct_jalr;
        ctrl.jump        = funct_jr | funct_jalr;
        ctrl.jump_reg    = funct_jr | funct_jalr;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump         = 1'b1;
        ctrl.reg_write    = 1'b1;
        ctrl.reg_dst_link = 1'b1;
        ctrl.link_to_reg  = 1'b1;
      end
      // Branches compare rs and rt by subtraction
      OP_BEQ: begin
        ctrl.alu_op = ALU_SUB;
        is_beq      = 1'b1;
      end
      OP_BNE: begin
        ctrl.alu_op = ALU_SUB;
        is_bne      = 1'b1;
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (opcode)
          OP_SLTI:  ctrl.alu_op = ALU_SLT;
          OP_SLTIU: ctrl.alu_op = ALU_SLTU;
          OP_ANDI:  ctrl.alu_op = ALU_AND;
          OP_ORI:   ctrl.alu_op = ALU_OR;
          OP_XORI:  ctrl.alu_op = ALU_XOR;
          OP_LUI:   ctrl.alu_op = ALU_LUI;
          default:  ctrl.alu_op = ALU_ADD;
        endcase
        // Logical immediates are zero extended
        ctrl.sign_ext_imm = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI});
      end
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
        ctrl.alu_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        data_read       = 1'b1;
        case (opcode)
          OP_LB:   ctrl.load_kind = LOAD_BYTE_SIGNED;
          OP_LBU:  ctrl.load_kind = LOAD_BYTE_UNSIGNED;
          OP_LH:   ctrl.load_kind = LOAD_HALF_SIGNED;
          OP_LHU:  ctrl.load_kind = LOAD_HALF_UNSIGNED;
          default: ctrl.load_kind = LOAD_WORD;
        endcase
      end
      OP_SW: begin
        ctrl.alu_src = 1'b1;
        data_write   = 1'b1;
      end
      default: ;
    endcase
  end

  // The branch resolves from the zero flag of the rs minus rt subtraction
  assign ctrl.pc_src = (is_beq & ctrl.zero) | (is_bne & ~ctrl.zero);

endmodule

//--- hw/mips_datapath.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_datapath (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clk_enable,
  output logic            active,
  mips_ctrl_if.dp         dp,
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  output mips_pkg::word_t data_address,
  output mips_pkg::word_t data_writedata,
  input  mips_pkg::word_t data_readdata,
  output mips_pkg::word_t register_v0
);
  import mips_pkg::*;

  word_t     pc;
  word_t     pc_delay;
  word_t     pc_next;
  word_t     pc_plus4;
  word_t     pc_delay_plus4;
  word_t     pc_link;
  word_t     imm_ext;
  word_t     branch_target;
  word_t     jump_target;
  word_t     src_a;
  word_t     src_b;
  word_t     rt_data;
  word_t     alu_y;
  logic      alu_zero;
  word_t     load_data;
  word_t     result;
  reg_addr_t write_reg;
  logic      reg_we;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  // The fetched word goes back to the decoder through the interface
  assign dp.instr      = instr_readdata;
  assign dp.zero       = alu_zero;
  assign instr_address = pc;

  // pc is the instruction executing now, pc_delay the one after it.
  // Any branch or jump only redirects pc_delay's successor, which is
  // what gives the delay slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= `MIPS_RESET_VECTOR;
      pc_delay <= `MIPS_RESET_VECTOR + 32'd4;
      active   <= 1'b1;
    end else if (clk_enable && active) begin
      pc       <= pc_delay;
      pc_delay <= pc_next;
      // Halt as soon as the halt address becomes the fetch address
      if (pc_delay == `MIPS_HALT_ADDRESS) begin
        active <= 1'b0;
      end
    end
  end

  assign pc_plus4       = pc + 32'd4;
  assign pc_delay_plus4 = pc_delay + 32'd4;
  // Return address skips the delay slot
  assign pc_link        = pc + 32'd8;

  // Logical immediates use zero extension, everything else sign extension
  assign imm_ext = dp.sign_ext_imm ? {{16{instr_readdata[15]}}, instr_readdata[15:0]}
                                   : {16'h0000, instr_readdata[15:0]};

  // Branch offset counts words from the delay-slot address
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

  // j and jal keep the top four bits of the delay-slot address
  assign jump_target = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};

  // Jumps take priority, a register jump uses rs directly
  always_comb begin
    if (dp.jump) begin
      pc_next = dp.jump_reg ? src_a : jump_target;
    end else if (dp.pc_src) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_delay_plus4;
    end
  end

  // Link instructions write $31, R-type writes rd, immediates write rt
  always_comb begin
    if (dp.reg_dst_link) begin
      write_reg = `MIPS_LINK_REG;
    end else if (dp.reg_dst_rd) begin
      write_reg = instr_readdata[15:11];
    end else begin
      write_reg = instr_readdata[20:16];
    end
  end

  // No write on a held edge or once the core has halted
  assign reg_we = dp.reg_write & clk_enable & active;

  mips_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (reg_we),
    .ra1    (instr_readdata[25:21]),
    .ra2    (instr_readdata[20:16]),
    .wa     (write_reg),
    .wd     (result),
    .rd1    (src_a),
    .rd2    (rt_data),
    .reg_v0 (register_v0)
  );

  assign src_b = dp.alu_src ? imm_ext : rt_data;

  mips_alu u_alu (
    .op    (dp.alu_op),
    .a     (src_a),
    .b     (src_b),
    .shamt (instr_readdata[10:6]),
    .y     (alu_y),
    .zero  (alu_zero)
  );

  // Loads and stores address memory with the ALU sum, stores send rt
  assign data_address   = alu_y;
  assign data_writedata = rt_data;

  // Memory is little-endian; the low address bits pick the byte lane
  always_comb begin
    case (alu_y[1:0])
      2'd0:    load_byte = data_readdata[7:0];
      2'd1:    load_byte = data_readdata[15:8];
      2'd2:    load_byte = data_readdata[23:16];
      default: load_byte = data_readdata[31:24];
    endcase
  end

  // Halfwords are aligned, so only bit 1 matters
  assign load_half = alu_y[1] ? data_readdata[31:16] : data_readdata[15:0];

  always_comb begin
    case (dp.load_kind)
      LOAD_BYTE_SIGNED:   load_data = {{24{load_byte[7]}}, load_byte};
      LOAD_BYTE_UNSIGNED: load_data = {24'h000000, load_byte};
      LOAD_HALF_SIGNED:   load_data = {{16{load_half[15]}}, load_half};
      LOAD_HALF_UNSIGNED: load_data = {16'h0000, load_half};
      default:            load_data = data_readdata;
    endcase
  end

  // Write-back picks the link address, then memory, then the ALU
  always_comb begin
    if (dp.link_to_reg) begin
      result = pc_link;
    end else if (dp.mem_to_reg) begin
      result = load_data;
    end else begin
      result = alu_y;
    end
  end

endmodule

//--- hw/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clk_enable,
  output logic            active,
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  output mips_pkg::word_t data_address,
  output mips_pkg::word_t data_writedata,
  input  mips_pkg::word_t data_readdata,
  output logic            data_write,
  output logic            data_read,
  output mips_pkg::word_t register_v0
);

  // Control levels and the fetched word pass between the two halves here
  mips_ctrl_if ctrl_bus ();

  // Memory strobes come straight from the decoded opcode
  mips_decoder u_decoder (
    .ctrl       (ctrl_bus.ctrl),
    .data_write (data_write),
    .data_read  (data_read)
  );

  // The datapath feeds instr_readdata into the interface for the decoder
  mips_datapath u_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .dp             (ctrl_bus.dp),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0)
  );

endmodule

//--- testbench/mips_cpu_chk.sv
`timescale 1ns/1ps

module mips_cpu_chk (
  input logic        clk,
  input logic        rst_n,
  input logic        clk_enable,
  input logic        active,
  input logic [31:0] instr_address,
  input logic        data_write,
  input logic        data_read
);

  // Reset always leaves the core running
  a_active_after_reset: assert property (@(posedge clk) !rst_n |=> active)
    else $error("active low in the cycle after reset");

  // A held edge must not move the fetch address
  a_hold_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !clk_enable |=> $stable(instr_address))
    else $error("instr_address moved while clk_enable was low");

  // One instruction is either a load or a store, never both
  a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_write && data_read))
    else $error("data_write and data_read high together");

  // Halt is permanent until the next reset
  a_halt_sticks: assert property (@(posedge clk) disable iff (!rst_n)
    !active |=> !active)
    else $error("active rose again without a reset");

endmodule

bind mips_cpu mips_cpu_chk chk (.*);

//--- testbench/mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_cpu_tb;

  logic        clk;
  logic        rst_n;
  logic        clk_enable;
  logic        active;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  logic        data_write;
  logic        data_read;
  logic [31:0] register_v0;

  // Program words from the reset vector on, and a small data memory
  logic [31:0] imem [64];
  logic [31:0] dmem [256];

  // Expected stores in program order, plus the final $v0 and step count
  logic [31:0] exp_store_addr [$];
  logic [31:0] exp_store_data [$];
  logic [31:0] exp_v0;
  int          exp_steps;

  int          enabled_steps;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lfsr_state;
  logic [31:0] imem_offset;

  mips_cpu UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata),
    .data_write     (data_write),
    .data_read      (data_read),
    .register_v0    (register_v0)
  );

  always #10 clk = ~clk;

  // Both memories answer in the same cycle; fetches outside the program read a nop
  assign imem_offset = instr_address - `MIPS_RESET_VECTOR;
  assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : 32'h0;
  assign data_readdata  = dmem[data_address[9:2]];

  // Galois LFSR that advances one step for each bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // MIPS-I load opcodes are lb, lh, lw, lbu and lhu
  function automatic logic is_load(input logic [31:0] word);
    return (word[31:26] inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25});
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      fail_run(msg);
    end
  endtask

  // Reads I, D, S, V and N lines; lines starting with # are notes
  task automatic read_trace();
    int          fd;
    int          r;
    int          ipos;
    string       line;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    ipos = 0;
    fd = $fopen("testbench/mips_trace.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the trace file testbench/mips_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      r = $fgets(line, fd);
      if (line.len() >= 3 && line[0] != "#") begin
        rest = line.substr(2, line.len() - 1);
        a = '0;
        b = '0;
        case (line[0])
          "I": begin
            r = $sscanf(rest, "%h", a);
            imem[ipos] = a;
            ipos++;
          end
          "D": begin
            r = $sscanf(rest, "%h %h", a, b);
            dmem[a[9:2]] = b;
          end
          "S": begin
            r = $sscanf(rest, "%h %h", a, b);
            exp_store_addr.push_back(a);
            exp_store_data.push_back(b);
          end
          "V": r = $sscanf(rest, "%h", exp_v0);
          "N": r = $sscanf(rest, "%d", exp_steps);
          default: fail_run("The trace file holds a line of unknown kind");
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Stores land on enabled edges and are compared with the next expected one
  always @(posedge clk) begin
    if (rst_n && clk_enable && data_write) begin
      if (exp_store_addr.size() == 0) begin
        fail_run("The core stored a word that the trace does not expect");
      end else begin
        check_value("data_address", data_address, exp_store_addr.pop_front());
        check_value("data_writedata", data_writedata, exp_store_data.pop_front());
        dmem[data_address[9:2]] = data_writedata;
      end
    end
    // Only a load instruction reads the data memory
    if (rst_n) begin
      check_value("data_read", {31'b0, data_read}, {31'b0, is_load(instr_readdata)});
    end
    // Each enabled edge while active retires one instruction
    if (rst_n && clk_enable && active) begin
      enabled_steps++;
    end
  end

  // Guards against a core that never halts
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        fail_run("Timeout: the core did not halt within the cycle limit");
      end
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    clk_enable    = 1'b0;
    enabled_steps = 0;
    cycle_count   = 0;
    exp_v0        = '0;
    exp_steps     = 0;
    lfsr_state    = 32'hcdfc;
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
    end
    // Fill pattern depends on the full word address
    for (int i = 0; i < 256; i++) begin
      dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
    read_trace();
    cycle_limit = 4 * exp_steps + 50;

    // Two clock cycles of reset
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Enable follows one LFSR bit per cycle until the core halts
    while (active === 1'b1) begin
      @(posedge clk);
      #1;
      lfsr_state = lfsr_next(lfsr_state);
      clk_enable = lfsr_state[0];
    end

    // A few more enabled edges must leave the halted core where it is
    clk_enable = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    check_value("active", {31'b0, active}, 32'h0);
    check_value("instr_address", instr_address, `MIPS_HALT_ADDRESS);
    check_value("register_v0", register_v0, exp_v0);
    check_value("enabled_steps", enabled_steps, exp_steps);
    check_value("stores_left", exp_store_addr.size(), 32'h0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- testbench/mips_trace.txt
# I word: program from the reset vector; D addr word: data preload
# S addr word: expected store in order; V word: final $v0; N count: steps
D 00000100 80F17F92
I 24010100
I 24030200
I 2404FFFB
I 24051234
I 00853021
I AC660000
I 00A43823
I AC670004
I 00854026
I AC680008
I 0085482A
I 0085502B
I 00055900
I 00046043
I 00046F02
I AC69000C
I AC6A0010
I AC6B0014
I AC6C0018
I AC6D001C
I 3C0EABCD
I 35CE8001
I AC6E0020
I 308FF0F0
I 38B0FFFF
I 2891FFFC
I 2CB2FFFF
I AC6F0024
I AC700028
I 02329821
I AC73002C
I 80340003
I 90350002
I 84360002
I 94370002
I 8C380000
I AC740030
I AC750034
I AC760038
I AC77003C
I AC780040
I 11310002
I AC650044
I AC640048
I 15290005
I AC66004C
I 0BF00031
I AC670050
I AC640054
I 0FF0003A
I AC680058
I 3C19BFC0
I 373900F4
I 0320D009
I AC7A0064
I 01D81021
I 00000008
I AC620068
I AC7F005C
I 03E00008
I AC690060
I 03400008
I AC73006C
S 00000200 0000122F
S 00000204 00001239
S 00000208 FFFFEDCF
S 0000020C 00000001
S 00000210 00000000
S 00000214 00012340
S 00000218 FFFFFFFD
S 0000021C 0000000F
S 00000220 ABCD8001
S 00000224 0000F0F0
S 00000228 0000EDCB
S 0000022C 00000002
S 00000230 FFFFFF80
S 00000234 000000F1
S 00000238 FFFF80F1
S 0000023C 000080F1
S 00000240 80F17F92
S 00000244 00001234
S 0000024C 0000122F
S 00000250 00001239
S 00000258 FFFFEDCF
S 0000025C BFC000CC
S 00000260 00000001
S 00000264 BFC000DC
S 0000026C 00000002
S 00000268 2CBEFF93
V 2CBEFF93
N 61

//--- project.f
+incdir+hw
hw/mips_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_decoder.sv
hw/mips_datapath.sv
hw/mips_cpu.sv
testbench/mips_cpu_chk.sv
testbench/mips_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mips_cpu_tb -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/Vmips_cpu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned a failing status"
  exit $status
fi

exit 0
